//--- all.f
verilog/fpga_rt_pkg.sv
verilog/rt_reg_block.sv
verilog/log_char_fifo.sv
verilog/itrng_feeder.sv
verilog/fpga_rt_top.sv
tb/tb_fpga_rt.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_fpga_rt -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
echo "Pass message not found"
exit 1

//--- tb/tb_fpga_rt.sv
//********************
// Testbench for the FPGA run-time wrapper
// Table-driven host bus, log FIFO and TRNG feeder checks
//********************
module tb_fpga_rt import fpga_rt_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [2:0] {
        op_read, op_write, op_push, op_req, op_nib, op_quiet, op_cyc
    } op_e;

    // count repeats reads (exp steps by one), or sets chars, pulses or idle cycles
    // For op_nib, data is the word and exp the required pulse spacing (0 = any)
    typedef struct packed {
        op_e         op;
        logic [7:0]  addr;
        logic [7:0]  count;
        logic [31:0] data;
        logic [31:0] exp;
        logic [31:0] mask;
        logic        err;
    } step_t;

    localparam int n_steps   = 39;
    localparam int bus_limit = 50;   // Cycles to wait for a response
    localparam int nib_limit = 400;  // Cycles to wait for one nibble

    step_t steps [n_steps] = '{
        // Divisor readback and error responses
        '{op_write, addr_itrng_divisor, 8'd1, 32'h0000_001c, 32'h0, 32'hffff_ffff, 1'b0},
        '{op_read,  addr_itrng_divisor, 8'd1, 32'h0, 32'h0000_001c, 32'hffff_ffff, 1'b0},
        '{op_read,  8'h20,              8'd1, 32'h0, 32'h0,         32'hffff_ffff, 1'b1},
        '{op_write, addr_cycle_count,   8'd1, 32'h1, 32'h0,         32'hffff_ffff, 1'b1},
        '{op_write, addr_log_data,      8'd1, 32'h1, 32'h0,         32'hffff_ffff, 1'b1},
        // Five characters in order and then empty
        '{op_push,  8'h00,              8'd5, 32'h61, 32'h0,        32'h0,         1'b0},
        '{op_read,  addr_log_data,      8'd5, 32'h0, 32'h0000_0161, 32'hffff_ffff, 1'b0},
        '{op_read,  addr_log_data,      8'd1, 32'h0, 32'h0,         32'h0000_0100, 1'b0},
        '{op_read,  addr_log_status,    8'd1, 32'h0, 32'h1,         32'hffff_ffff, 1'b0},
        // Overflow drops the last four
        '{op_push,  8'h00,              8'd20, 32'h40, 32'h0,       32'h0,         1'b0},
        '{op_read,  addr_log_status,    8'd1, 32'h0, 32'h2,         32'hffff_ffff, 1'b0},
        '{op_read,  addr_log_data,      8'd16, 32'h0, 32'h0000_0140, 32'hffff_ffff, 1'b0},
        '{op_read,  addr_log_data,      8'd1, 32'h0, 32'h0,         32'h0000_0100, 1'b0},
        '{op_read,  addr_log_status,    8'd1, 32'h0, 32'h1,         32'hffff_ffff, 1'b0},
        // Divisor 0 gives nibbles back to back
        '{op_write, addr_itrng_divisor, 8'd1, 32'h0, 32'h0,         32'hffff_ffff, 1'b0},
        '{op_write, addr_itrng_data,    8'd1, 32'h3c5a_96e1, 32'h0, 32'hffff_ffff, 1'b0},
        '{op_write, addr_itrng_data,    8'd1, 32'h0f1e_2d4b, 32'h0, 32'hffff_ffff, 1'b0},
        '{op_req,   8'h00,              8'd0, 32'h1, 32'h0,         32'h0,         1'b0},
        '{op_nib,   8'h00,              8'd8, 32'h3c5a_96e1, 32'd0, 32'h0,         1'b0},
        '{op_nib,   8'h00,              8'd8, 32'h0f1e_2d4b, 32'd0, 32'h0,         1'b0},
        '{op_read,  addr_itrng_status,  8'd1, 32'h0, 32'h1,         32'hffff_ffff, 1'b0},
        '{op_req,   8'h00,              8'd0, 32'h0, 32'h0,         32'h0,         1'b0},
        // Divisor 5 gives one pulse every 6 cycles
        '{op_write, addr_itrng_divisor, 8'd1, 32'h5, 32'h0,         32'hffff_ffff, 1'b0},
        '{op_write, addr_itrng_data,    8'd1, 32'h8b7d_14f6, 32'h0, 32'hffff_ffff, 1'b0},
        '{op_write, addr_itrng_data,    8'd1, 32'hc293_e05a, 32'h0, 32'hffff_ffff, 1'b0},
        '{op_req,   8'h00,              8'd0, 32'h1, 32'h0,         32'h0,         1'b0},
        '{op_nib,   8'h00,              8'd8, 32'h8b7d_14f6, 32'd6, 32'h0,         1'b0},
        '{op_nib,   8'h00,              8'd8, 32'hc293_e05a, 32'd6, 32'h0,         1'b0},
        '{op_read,  addr_itrng_status,  8'd1, 32'h0, 32'h1,         32'hffff_ffff, 1'b0},
        '{op_req,   8'h00,              8'd0, 32'h0, 32'h0,         32'h0,         1'b0},
        // Feeder flush followed by silence
        '{op_write, addr_itrng_divisor, 8'd1, 32'h0, 32'h0,         32'hffff_ffff, 1'b0},
        '{op_write, addr_itrng_data,    8'd1, 32'h5555_aaaa, 32'h0, 32'hffff_ffff, 1'b0},
        '{op_read,  addr_itrng_status,  8'd1, 32'h0, 32'h0,         32'hffff_ffff, 1'b0},
        '{op_write, addr_itrng_status,  8'd1, 32'h4, 32'h0,         32'hffff_ffff, 1'b0},
        '{op_read,  addr_itrng_status,  8'd1, 32'h0, 32'h1,         32'hffff_ffff, 1'b0},
        '{op_req,   8'h00,              8'd0, 32'h1, 32'h0,         32'h0,         1'b0},
        '{op_quiet, 8'h00,              8'd50, 32'h0, 32'h0,        32'h0,         1'b0},
        '{op_req,   8'h00,              8'd0, 32'h0, 32'h0,         32'h0,         1'b0},
        '{op_cyc,   addr_cycle_count,   8'd1, 32'h0, 32'h0,         32'h0,         1'b0}
    };

    logic          core_clk;
    logic          hwif_out;
    logic          req_valid;
    reg_req_t      req;
    logic          req_ready;
    logic          rsp_valid;
    reg_rsp_t      rsp;
    logic          rsp_ready;
    logic          log_char_valid;
    logic [7:0]    log_char;
    logic          etrng_req;
    logic          itrng_valid;
    logic [3:0]    itrng_data;

    int errors = 0;
    int cyc = 0;          // Clock edges since start
    int last_pulse = -1;  // Edge of the previous nibble pulse

    fpga_rt_top dut (.*);

    initial begin
        core_clk = 1'b0;
        forever #10 core_clk = ~core_clk;
    end

    always @(posedge core_clk) cyc <= cyc + 1;

    task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (exp === got) else begin
            errors++;
            $display("[ERROR] %s expected %h got %h", name, exp, got);
        end
    endtask

    // One host transfer with a random stall before the response is taken
    task automatic bus_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output reg_rsp_t r);
        int t;
        int hold;
        reg_rsp_t first;
        t = 0;
        r = '0;
        req_valid = 1'b1;
        req = '{write: wr, addr: addr, wdata: wdata};
        do begin
            @(posedge core_clk);
            #2;
            t++;
        end while (!rsp_valid && t < bus_limit);
        req_valid = 1'b0;
        assert (rsp_valid) else begin
            errors++;
            $display("Timeout: no response to the request at address %h", addr);
        end
        if (rsp_valid) begin
            // Idle bus accepts at the first edge, response one cycle later
            check_equal("rsp_valid latency", 32'h1, 32'(t));
            check_equal("req_ready", 32'h0, 32'(req_ready));
            first = rsp;
            hold = int'($urandom % 32'd4);
            repeat (hold) begin
                @(posedge core_clk);
                #2;
                assert (rsp_valid && rsp === first) else begin
                    errors++;
                    $display("[ERROR] rsp expected %h got %h while stalled", first, rsp);
                end
            end
            r = first;
            rsp_ready = 1'b1;
            @(posedge core_clk);
            #2;
            rsp_ready = 1'b0;
        end
    endtask

    // Waits for each pulse and checks nibble and spacing
    task automatic wait_nibbles(input logic [31:0] word, input int n, input int gap);
        int t;
        for (int i = 0; i < n; i++) begin
            t = 0;
            do begin
                @(posedge core_clk);
                #2;
                t++;
            end while (!itrng_valid && t < nib_limit);
            assert (itrng_valid) else begin
                errors++;
                $display("Timeout: nibble %0d of word %h never arrived", i, word);
            end
            if (!itrng_valid) begin
                break;
            end
            check_equal("itrng_data", 32'(word[4*i +: 4]), 32'(itrng_data));
            if (gap != 0 && last_pulse >= 0) begin
                check_equal("itrng_valid spacing", 32'(gap), 32'(cyc - last_pulse));
            end
            last_pulse = cyc;
        end
    endtask

    initial begin
        reg_rsp_t r;
        reg_rsp_t r2;
        step_t    st;
        void'($urandom(32'h96afe0d2));
        hwif_out       = 1'b0;
        req_valid      = 1'b0;
        req            = '0;
        rsp_ready      = 1'b0;
        log_char_valid = 1'b0;
        log_char       = '0;
        etrng_req      = 1'b0;
        repeat (10) @(posedge core_clk);
        #2;
        hwif_out = 1'b1;
        check_equal("req_ready", 32'h1, 32'(req_ready));
        check_equal("rsp_valid", 32'h0, 32'(rsp_valid));
        check_equal("itrng_valid", 32'h0, 32'(itrng_valid));

        for (int s = 0; s < n_steps; s++) begin
            st = steps[s];
            case (st.op)
                op_read, op_write: begin
                    for (int k = 0; k < int'(st.count); k++) begin
                        bus_xfer(st.op == op_write, st.addr, st.data, r);
                        check_equal("rsp.rdata", (st.exp + 32'(k)) & st.mask,
                                    r.rdata & st.mask);
                        check_equal("rsp.err", 32'(st.err), 32'(r.err));
                    end
                end
                op_push: begin
                    for (int k = 0; k < int'(st.count); k++) begin
                        log_char_valid = 1'b1;
                        log_char       = st.data[7:0] + 8'(k);
                        @(posedge core_clk);
                        #2;
                    end
                    log_char_valid = 1'b0;
                end
                op_req: begin
                    etrng_req  = st.data[0];
                    last_pulse = -1;
                end
                op_nib: wait_nibbles(st.data, int'(st.count), int'(st.exp));
                op_quiet: begin
                    repeat (int'(st.count)) begin
                        @(posedge core_clk);
                        #2;
                        check_equal("itrng_valid", 32'h0, 32'(itrng_valid));
                    end
                end
                default: begin
                    bus_xfer(1'b0, st.addr, 32'h0, r);
                    bus_xfer(1'b0, st.addr, 32'h0, r2);
                    check_equal("rsp.err", 32'h0, 32'(r.err | r2.err));
                    assert (r2.rdata > r.rdata) else begin
                        errors++;
                        $display("[ERROR] cycle count did not grow: %h then %h",
                                 r.rdata, r2.rdata);
                    end
                end
            endcase
        end

        $display("Run complete with %0d error(s)", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- verilog/fpga_rt_pkg.sv
//********************
// Run-time wrapper shared definitions
// Register map, widths, FIFO depths and host bus types
//********************
package fpga_rt_pkg;

    // Host bus widths
    localparam int reg_addr_w = 8;
    localparam int reg_data_w = 32;

    // Register byte addresses
    localparam logic [reg_addr_w-1:0] addr_itrng_divisor = 8'h04;
    localparam logic [reg_addr_w-1:0] addr_itrng_data    = 8'h08;  // Write pushes a word
    localparam logic [reg_addr_w-1:0] addr_itrng_status  = 8'h0C;
    localparam logic [reg_addr_w-1:0] addr_log_data      = 8'h10;  // Read pops a char
    localparam logic [reg_addr_w-1:0] addr_log_status    = 8'h14;
    localparam logic [reg_addr_w-1:0] addr_cycle_count   = 8'h18;

    // Status and control bit positions
    localparam int stat_empty_bit  = 0;
    localparam int stat_full_bit   = 1;
    localparam int itrng_clear_bit = 2;

    // Log character path
    localparam int log_char_w     = 8;
    localparam int log_fifo_depth = 16;
    localparam int log_ptr_w      = $clog2(log_fifo_depth);

    // Entropy path
    localparam int nibble_w         = 4;
    localparam int nibbles_per_word = 8;
    localparam int nib_idx_w        = $clog2(nibbles_per_word);
    localparam int itrng_fifo_depth = 4;
    localparam int itrng_ptr_w      = $clog2(itrng_fifo_depth);

    // Host request, 41 bits
    typedef struct packed {
        logic                  write;
        logic [reg_addr_w-1:0] addr;
        logic [reg_data_w-1:0] wdata;
    } reg_req_t;

    // Host response, 33 bits
    typedef struct packed {
        logic [reg_data_w-1:0] rdata;
        logic                  err;
    } reg_rsp_t;

    // Entropy word, written whole and consumed a nibble at a time
    // Nibble 0 sits in bits 3:0
    typedef union packed {
        logic [reg_data_w-1:0]                     word;
        logic [nibbles_per_word-1:0][nibble_w-1:0] nib;
    } itrng_word_u;

endpackage

//--- verilog/fpga_rt_top.sv
//********************
// FPGA run-time wrapper top level
// Host registers, log FIFO and TRNG feeder
//********************
module fpga_rt_top import fpga_rt_pkg::*; (
    input  logic                  core_clk,
    input  logic                  hwif_out,
    input  logic                  req_valid,
    input  reg_req_t              req,
    output logic                  req_ready,
    output logic                  rsp_valid,
    output reg_rsp_t              rsp,
    input  logic                  rsp_ready,
    input  logic                  log_char_valid,
    input  logic [log_char_w-1:0] log_char,
    input  logic                  etrng_req,
    output logic                  itrng_valid,
    output logic [nibble_w-1:0]   itrng_data
);

    // Register block to FIFOs
    logic [log_char_w-1:0] log_head;
    logic                  log_empty;
    logic                  log_full;
    logic                  log_pop;
    logic                  itrng_empty;
    logic                  itrng_full;
    logic                  itrng_push;
    logic [reg_data_w-1:0] itrng_word;
    logic                  itrng_clear;
    logic [reg_data_w-1:0] itrng_divisor;

    rt_reg_block u_regs (
        .core_clk      (core_clk),
        .hwif_out      (hwif_out),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .rsp_ready     (rsp_ready),
        .log_head      (log_head),
        .log_empty     (log_empty),
        .log_full      (log_full),
        .log_pop       (log_pop),
        .itrng_empty   (itrng_empty),
        .itrng_full    (itrng_full),
        .itrng_push    (itrng_push),
        .itrng_word    (itrng_word),
        .itrng_clear   (itrng_clear),
        .itrng_divisor (itrng_divisor)
    );

    log_char_fifo u_log_fifo (
        .core_clk       (core_clk),
        .hwif_out       (hwif_out),
        .log_char_valid (log_char_valid),
        .log_char       (log_char),
        .log_pop        (log_pop),
        .log_head       (log_head),
        .log_empty      (log_empty),
        .log_full       (log_full)
    );

    itrng_feeder u_itrng (
        .core_clk      (core_clk),
        .hwif_out      (hwif_out),
        .itrng_push    (itrng_push),
        .itrng_word    (itrng_word),
        .itrng_clear   (itrng_clear),
        .itrng_divisor (itrng_divisor),
        .etrng_req     (etrng_req),
        .itrng_empty   (itrng_empty),
        .itrng_full    (itrng_full),
        .itrng_valid   (itrng_valid),
        .itrng_data    (itrng_data)
    );

endmodule

//--- verilog/itrng_feeder.sv
//********************
// Internal TRNG feeder
// Queues host entropy words and hands them out as nibbles,
// lowest first, paced by a divisor-reloaded down-counter
//********************
module itrng_feeder import fpga_rt_pkg::*; (
    input  logic                  core_clk,
    input  logic                  hwif_out,
    input  logic                  itrng_push,
    input  logic [reg_data_w-1:0] itrng_word,
    input  logic                  itrng_clear,
    input  logic [reg_data_w-1:0] itrng_divisor,
    input  logic                  etrng_req,
    output logic                  itrng_empty,
    output logic                  itrng_full,
    output logic                  itrng_valid,
    output logic [nibble_w-1:0]   itrng_data
);

    itrng_word_u            words [itrng_fifo_depth];
    logic [itrng_ptr_w-1:0] wr_ptr;
    logic [itrng_ptr_w-1:0] rd_ptr;
    logic [itrng_ptr_w:0]   count;
    logic [nib_idx_w-1:0]   nib_idx;
    logic [reg_data_w-1:0]  throttle;
    logic                   push_en;
    logic                   grant;
    logic                   last_nib;
    logic                   pop_en;

    assign itrng_empty = (count == '0);
    assign itrng_full  = (count == (itrng_ptr_w + 1)'(itrng_fifo_depth));

    assign push_en  = itrng_push & ~itrng_full;
    assign grant    = (throttle == '0) & etrng_req & ~itrng_empty;
    assign last_nib = (nib_idx == nib_idx_w'(nibbles_per_word - 1));
    assign pop_en   = grant & last_nib;  // Word retires with its eighth nibble

    always_ff @(posedge core_clk) begin
        if (push_en) begin
            words[wr_ptr].word <= itrng_word;
        end
    end

    // Queue pointers and nibble index
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            nib_idx <= '0;
        end else if (itrng_clear) begin
            wr_ptr  <= '0;  // Host-requested flush
            rd_ptr  <= '0;
            count   <= '0;
            nib_idx <= '0;
        end else begin
            if (push_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (grant) begin
                nib_idx <= nib_idx + 1'b1;  // Wraps to 0 after the eighth nibble
            end
            if (pop_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_en, pop_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Throttle giving one grant slot every divisor+1 cycles
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            throttle    <= '0;
            itrng_valid <= 1'b0;
        end else begin
            itrng_valid <= grant;
            if (throttle == '0) begin
                throttle <= itrng_divisor;
            end else begin
                throttle <= throttle - 1'b1;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (grant) begin
            itrng_data <= words[rd_ptr].nib[nib_idx];
        end
    end

    // Back-to-back pulses only with a zero divisor at the reload
    itrng_pace_a: assert property (@(posedge core_clk) disable iff (!hwif_out)
        itrng_valid && ($past(itrng_divisor) != '0) |=> !itrng_valid);

endmodule

//--- verilog/log_char_fifo.sv
//********************
// Debug log character FIFO
// Fall-through head, drops characters while full
//********************
module log_char_fifo import fpga_rt_pkg::*; (
    input  logic                  core_clk,
    input  logic                  hwif_out,
    input  logic                  log_char_valid,
    input  logic [log_char_w-1:0] log_char,
    input  logic                  log_pop,
    output logic [log_char_w-1:0] log_head,
    output logic                  log_empty,
    output logic                  log_full
);

    logic [log_char_w-1:0] mem [log_fifo_depth];
    logic [log_ptr_w-1:0]  wr_ptr;
    logic [log_ptr_w-1:0]  rd_ptr;
    logic [log_ptr_w:0]    count;
    logic                  wr_en;
    logic                  rd_en;

    assign log_empty = (count == '0);
    assign log_full  = (count == (log_ptr_w + 1)'(log_fifo_depth));

    assign wr_en = log_char_valid & ~log_full;  // Overflow is lost
    assign rd_en = log_pop & ~log_empty;

    assign log_head = mem[rd_ptr];  // Fall-through

    always_ff @(posedge core_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= log_char;
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Occupancy bound
    log_occ_a: assert property (@(posedge core_clk) disable iff (!hwif_out)
        count <= (log_ptr_w + 1)'(log_fifo_depth));

endmodule

//--- verilog/rt_reg_block.sv
//********************
// Host register block
// Single outstanding valid/ready request, registered response,
// divisor register and free-running cycle counter
//********************
module rt_reg_block import fpga_rt_pkg::*; (
    input  logic                  core_clk,
    input  logic                  hwif_out,
    input  logic                  req_valid,
    input  reg_req_t              req,
    output logic                  req_ready,
    output logic                  rsp_valid,
    output reg_rsp_t              rsp,
    input  logic                  rsp_ready,
    input  logic [log_char_w-1:0] log_head,
    input  logic                  log_empty,
    input  logic                  log_full,
    output logic                  log_pop,
    input  logic                  itrng_empty,
    input  logic                  itrng_full,
    output logic                  itrng_push,
    output logic [reg_data_w-1:0] itrng_word,
    output logic                  itrng_clear,
    output logic [reg_data_w-1:0] itrng_divisor
);

    logic                  accept;
    logic                  div_we;
    reg_rsp_t              rsp_d;
    logic [reg_data_w-1:0] cycle_count;

    // Busy from acceptance until the response leaves
    assign req_ready = ~rsp_valid;
    assign accept    = req_valid & req_ready;

    assign itrng_word = req.wdata;  // Only sampled on a push

    // Address decode, strobes and next response
    always_comb begin
        rsp_d       = '0;
        div_we      = 1'b0;
        log_pop     = 1'b0;
        itrng_push  = 1'b0;
        itrng_clear = 1'b0;
        case (req.addr)
            addr_itrng_divisor: begin
                if (req.write) begin
                    div_we = accept;
                end else begin
                    rsp_d.rdata = itrng_divisor;
                end
            end
            addr_itrng_data: begin
                itrng_push = accept & req.write;  // Reads return zero
            end
            addr_itrng_status: begin
                if (req.write) begin
                    itrng_clear = accept & req.wdata[itrng_clear_bit];
                end else begin
                    rsp_d.rdata[stat_empty_bit] = itrng_empty;
                    rsp_d.rdata[stat_full_bit]  = itrng_full;
                end
            end
            addr_log_data: begin
                if (req.write) begin
                    rsp_d.err = 1'b1;
                end else begin
                    // Head and valid as seen at acceptance
                    rsp_d.rdata[log_char_w-1:0] = log_head;
                    rsp_d.rdata[log_char_w]     = ~log_empty;
                    log_pop                     = accept;
                end
            end
            addr_log_status: begin
                if (req.write) begin
                    rsp_d.err = 1'b1;
                end else begin
                    rsp_d.rdata[stat_empty_bit] = log_empty;
                    rsp_d.rdata[stat_full_bit]  = log_full;
                end
            end
            addr_cycle_count: begin
                if (req.write) begin
                    rsp_d.err = 1'b1;
                end else begin
                    rsp_d.rdata = cycle_count;
                end
            end
            default: begin
                rsp_d.err = 1'b1;  // Unmapped
            end
        endcase
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // Response payload, loaded only at acceptance
    always_ff @(posedge core_clk) begin
        if (accept) begin
            rsp <= rsp_d;
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            itrng_divisor <= '0;
            cycle_count   <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
            if (div_we) begin
                itrng_divisor <= req.wdata;
            end
        end
    end

    // Response must hold still while the host stalls it
    rsp_hold_a: assert property (@(posedge core_clk) disable iff (!hwif_out)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule
